/* tlp_width.f */
verilog/tlp_stream_pkg.sv
verilog/tlp_core_if.sv
verilog/tlp_wide_if.sv
verilog/tlp_rx_packer.sv
verilog/tlp_tx_splitter.sv
verilog/pcie_status_ctrl.sv
verilog/tlp_width_top.sv
verif/tb_tlp_width.sv

/* verif/tb_tlp_width.sv */
/*
 * Testbench for the TLP stream width adapter. Applies a table of receive,
 * transmit, back-pressure and reset cases to tlp_width_top, models the
 * expected packed and split beats, and checks the LED on every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_tlp_width import tlp_stream_pkg::*; ();

    localparam int NUM_ROWS = 19;
    localparam int DIR_RX   = 0;
    localparam int DIR_TX   = 1;

    typedef struct {
        string       name;
        int          dir;
        int          pulse;   // 0 none, 1 soft reset, 2 user reset
        bit          stall;
        int          n;
        logic [31:0] items;   // One nibble per beat, beat 0 lowest
        logic [6:0]  bar;
        bit          link;
    } row_t;

    typedef struct packed {
        logic [127:0] data;
        logic [3:0]   keep;
        logic         last;
        logic         first;
        logic [6:0]   bar;
    } wide_beat_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
    } core_beat_t;

    logic         clk_pcie;
    logic         rst;
    logic         user_reset;
    logic         soft_rst_subsys;
    logic         link_up;
    logic [63:0]  core_rx_data;
    logic [7:0]   core_rx_keep;
    logic         core_rx_last;
    logic         core_rx_valid;
    logic [21:0]  core_rx_user;
    logic [127:0] wide_rx_data;
    logic [3:0]   wide_rx_keepdw;
    logic         wide_rx_last;
    logic         wide_rx_valid;
    logic         wide_rx_first;
    logic [6:0]   wide_rx_bar_hit;
    logic [127:0] wide_tx_data;
    logic [3:0]   wide_tx_keepdw;
    logic         wide_tx_last;
    logic         wide_tx_valid;
    logic         wide_tx_ready;
    logic [63:0]  core_tx_data;
    logic [7:0]   core_tx_keep;
    logic         core_tx_last;
    logic         core_tx_valid;
    logic         core_tx_ready;
    logic         led_state;

    row_t        rows [NUM_ROWS];
    wide_beat_t  got_rx [$];
    wide_beat_t  exp_rx [$];
    core_beat_t  got_tx [$];
    core_beat_t  exp_tx [$];
    int          wide_acc;
    int          err_cnt;
    int          fail_rows;
    int          cycle_cnt;
    int          cycle_limit;
    int          led_cycles;
    bit          stall_en;
    bit          led_check_en;
    string       cur_name;
    int unsigned rnd_seed;

    tlp_width_top u_tlp_width_top (.*);

    always #50 clk_pcie = ~clk_pcie;

    // --------------------------------------------------
    // Monitors and free-running checks
    // --------------------------------------------------
    always @(posedge clk_pcie) begin
        if (!rst && wide_rx_valid) begin
            got_rx.push_back({wide_rx_data, wide_rx_keepdw, wide_rx_last,
                              wide_rx_first, wide_rx_bar_hit});
        end
        if (!rst && core_tx_valid && core_tx_ready) begin
            got_tx.push_back({core_tx_data, core_tx_keep, core_tx_last});
        end
        // A wide beat counts only when consumed together with a core transfer
        if (!rst && wide_tx_valid && wide_tx_ready && core_tx_ready) begin
            wide_acc++;
        end
    end

    // LED is solid with the link and dark before the first blink
    always @(posedge clk_pcie) begin
        if (led_check_en) begin
            led_cycles++;
            if (led_cycles < (1 << LED_BLINK_BIT) && led_state !== link_up) begin
                $display("FAILED %s: led_state expected %b actual %b",
                         cur_name, link_up, led_state);
                err_cnt++;
            end
        end
    end

    always @(negedge clk_pcie) begin
        if (stall_en) begin
            core_tx_ready = ($urandom % 4) != 0;
        end else begin
            core_tx_ready = 1'b1;
        end
    end

    always @(posedge clk_pcie) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic report_mismatch(input string what, input logic [127:0] exp_val,
                                   input logic [127:0] act_val);
        $display("FAILED %s: %s expected %0h actual %0h", cur_name, what, exp_val, act_val);
        err_cnt++;
    endtask

    function automatic logic [127:0] dword_mask(input logic [3:0] keep);
        logic [127:0] m;
        m = '0;
        for (int j = 0; j < 4; j++) begin
            if (keep[j]) m[32*j +: 32] = 32'hffff_ffff;
        end
        return m;
    endfunction

    task automatic pulse_reset(input int src);
        @(negedge clk_pcie);
        soft_rst_subsys = (src == 1);
        user_reset      = (src == 2);
        @(negedge clk_pcie);
        soft_rst_subsys = 1'b0;
        user_reset      = 1'b0;
    endtask

    task automatic run_rx_row(input int r);
        int           d;
        int           cnt;
        int           waited;
        bit           first_pend;
        logic [63:0]  word;
        wide_beat_t   eb;
        logic [127:0] m;
        exp_rx.delete();
        got_rx.delete();
        cnt = 0;
        first_pend = 1'b1;
        eb = '0;
        for (int i = 0; i < rows[r].n; i++) begin
            d = rows[r].items[4*i +: 4];
            word = {$urandom, $urandom};
            @(negedge clk_pcie);
            core_rx_valid = 1'b1;
            core_rx_data  = word;
            core_rx_keep  = (d == 2) ? 8'hff : 8'h0f;
            core_rx_last  = (i == rows[r].n - 1) && (rows[r].pulse == 0);
            core_rx_user  = 22'($urandom);
            core_rx_user[8:2] = rows[r].bar;
            // Dwords land at the running offset
            eb.data[32*cnt +: 32] = word[31:0];
            if (d == 2) eb.data[32*(cnt+1) +: 32] = word[63:32];
            cnt += d;
            if (cnt >= 3 || core_rx_last) begin
                eb.keep  = 4'((1 << cnt) - 1);
                eb.last  = core_rx_last;
                eb.first = first_pend;
                eb.bar   = rows[r].bar;
                exp_rx.push_back(eb);
                first_pend = 1'b0;
                cnt = 0;
                eb = '0;
            end
        end
        @(negedge clk_pcie);
        core_rx_valid = 1'b0;
        core_rx_last  = 1'b0;
        if (rows[r].pulse != 0) pulse_reset(rows[r].pulse);
        waited = 0;
        while (got_rx.size() < exp_rx.size() && waited < 8) begin
            @(negedge clk_pcie);
            waited++;
        end
        repeat (3) @(negedge clk_pcie);
        if (got_rx.size() != exp_rx.size()) begin
            report_mismatch("wide beat count", exp_rx.size(), got_rx.size());
        end
        for (int i = 0; i < exp_rx.size() && i < got_rx.size(); i++) begin
            m = dword_mask(exp_rx[i].keep);
            if ((got_rx[i].data & m) !== exp_rx[i].data)
                report_mismatch("wide data", exp_rx[i].data, got_rx[i].data & m);
            if (got_rx[i].keep !== exp_rx[i].keep)
                report_mismatch("tkeepdw", exp_rx[i].keep, got_rx[i].keep);
            if (got_rx[i].last !== exp_rx[i].last)
                report_mismatch("tlast", exp_rx[i].last, got_rx[i].last);
            if (got_rx[i].first !== exp_rx[i].first)
                report_mismatch("first", exp_rx[i].first, got_rx[i].first);
            if (got_rx[i].bar !== exp_rx[i].bar)
                report_mismatch("bar_hit", exp_rx[i].bar, got_rx[i].bar);
        end
    endtask

    task automatic run_tx_row(input int r);
        logic [3:0]   k;
        logic [127:0] d;
        logic         l;
        int           waited;
        core_beat_t   cb;
        exp_tx.delete();
        got_tx.delete();
        wide_acc = 0;
        for (int i = 0; i < rows[r].n; i++) begin
            k = rows[r].items[4*i +: 4];
            d = {$urandom, $urandom, $urandom, $urandom};
            l = (i == rows[r].n - 1);
            // Low half first, high half only when dword 2 is valid
            cb.data = d[63:0];
            cb.keep = k[1] ? KEEP_TWO_DW : KEEP_ONE_DW;
            cb.last = l && !k[2];
            exp_tx.push_back(cb);
            if (k[2]) begin
                cb.data = d[127:64];
                cb.keep = k[3] ? KEEP_TWO_DW : KEEP_ONE_DW;
                cb.last = l;
                exp_tx.push_back(cb);
            end
            @(negedge clk_pcie);
            wide_tx_valid  = 1'b1;
            wide_tx_data   = d;
            wide_tx_keepdw = k;
            wide_tx_last   = l;
            do @(posedge clk_pcie); while (!wide_tx_ready);
        end
        @(negedge clk_pcie);
        wide_tx_valid = 1'b0;
        waited = 0;
        while (got_tx.size() < exp_tx.size() && waited < 8) begin
            @(negedge clk_pcie);
            waited++;
        end
        repeat (2) @(negedge clk_pcie);
        if (got_tx.size() != exp_tx.size())
            report_mismatch("core beat count", exp_tx.size(), got_tx.size());
        if (wide_acc != rows[r].n)
            report_mismatch("wide beats accepted", rows[r].n, wide_acc);
        for (int i = 0; i < exp_tx.size() && i < got_tx.size(); i++) begin
            if (got_tx[i].data !== exp_tx[i].data)
                report_mismatch("core data", exp_tx[i].data, got_tx[i].data);
            if (got_tx[i].keep !== exp_tx[i].keep)
                report_mismatch("core keep", exp_tx[i].keep, got_tx[i].keep);
            if (got_tx[i].last !== exp_tx[i].last)
                report_mismatch("core last", exp_tx[i].last, got_tx[i].last);
        end
    endtask

    // --------------------------------------------------
    // Test table and main sequence
    // --------------------------------------------------
    initial begin
        int errs_before;
        int total_beats;
        rnd_seed = $urandom(32'h0f56_2344);
        clk_pcie = 1'b0;
        rst = 1'b1;
        user_reset = 1'b0;
        soft_rst_subsys = 1'b0;
        link_up = 1'b0;
        core_rx_data = '0;
        core_rx_keep = '0;
        core_rx_last = 1'b0;
        core_rx_valid = 1'b0;
        core_rx_user = '0;
        wide_tx_data = '0;
        wide_tx_keepdw = '0;
        wide_tx_last = 1'b0;
        wide_tx_valid = 1'b0;
        core_tx_ready = 1'b1;

        // Receive items are dwords per core beat, transmit items are tkeepdw
        rows[0]  = '{"rx_1dw",        DIR_RX, 0, 1'b0, 1, 32'h1,      7'h01, 1'b0};
        rows[1]  = '{"rx_2dw",        DIR_RX, 0, 1'b0, 1, 32'h2,      7'h02, 1'b1};
        rows[2]  = '{"rx_3dw",        DIR_RX, 0, 1'b0, 2, 32'h21,     7'h04, 1'b0};
        rows[3]  = '{"rx_4dw",        DIR_RX, 0, 1'b0, 2, 32'h22,     7'h08, 1'b1};
        rows[4]  = '{"rx_5dw",        DIR_RX, 0, 1'b0, 3, 32'h212,    7'h10, 1'b0};
        rows[5]  = '{"rx_6dw",        DIR_RX, 0, 1'b0, 4, 32'h2121,   7'h20, 1'b1};
        rows[6]  = '{"rx_7dw",        DIR_RX, 0, 1'b0, 5, 32'h21211,  7'h40, 1'b0};
        rows[7]  = '{"rx_9dw",        DIR_RX, 0, 1'b0, 5, 32'h12222,  7'h7f, 1'b1};
        rows[8]  = '{"rst_soft_mid",  DIR_RX, 1, 1'b0, 2, 32'h11,     7'h15, 1'b0};
        rows[9]  = '{"rx_after_soft", DIR_RX, 0, 1'b0, 2, 32'h22,     7'h15, 1'b0};
        rows[10] = '{"rst_user_mid",  DIR_RX, 2, 1'b0, 1, 32'h2,      7'h2a, 1'b1};
        rows[11] = '{"rx_after_user", DIR_RX, 0, 1'b0, 3, 32'h111,    7'h2a, 1'b1};
        rows[12] = '{"tx_one_dw",     DIR_TX, 0, 1'b0, 1, 32'h1,      7'h00, 1'b0};
        rows[13] = '{"tx_mixed_a",    DIR_TX, 0, 1'b0, 4, 32'h1f73,   7'h00, 1'b1};
        rows[14] = '{"tx_mixed_b",    DIR_TX, 0, 1'b0, 4, 32'h73f1,   7'h00, 1'b0};
        rows[15] = '{"tx_four_dw",    DIR_TX, 0, 1'b0, 1, 32'hf,      7'h00, 1'b1};
        rows[16] = '{"tx_two_dw",     DIR_TX, 0, 1'b0, 1, 32'h3,      7'h00, 1'b0};
        rows[17] = '{"tx_stall_a",    DIR_TX, 0, 1'b1, 4, 32'h1f73,   7'h00, 1'b1};
        rows[18] = '{"tx_stall_b",    DIR_TX, 0, 1'b1, 6, 32'hf317ff, 7'h00, 1'b0};

        total_beats = 0;
        for (int r = 0; r < NUM_ROWS; r++) total_beats += rows[r].n;
        cycle_limit = total_beats * 4 + 200;

        repeat (16) @(negedge clk_pcie);
        rst = 1'b0;
        led_check_en = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            errs_before = err_cnt;
            @(posedge clk_pcie);
            stall_en = rows[r].stall;
            @(negedge clk_pcie);
            cur_name = rows[r].name;
            link_up  = rows[r].link;
            if (rows[r].dir == DIR_RX) begin
                run_rx_row(r);
            end else begin
                run_tx_row(r);
            end
            if (err_cnt == errs_before) begin
                $display("Test %-14s ok", rows[r].name);
            end else begin
                $display("Test %-14s %0d errors", rows[r].name, err_cnt - errs_before);
                fail_rows++;
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_ROWS, NUM_ROWS - fail_rows, fail_rows, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/pcie_status_ctrl.sv */
/*
 * Subsystem reset and link LED. Registers the OR of the system, core
 * and software resets for the receive side, and blinks the LED from a
 * free-running counter while the link is down.
 */

`timescale 1ns/1ps
`default_nettype none

module pcie_status_ctrl import tlp_stream_pkg::*; (
    input  logic clk_pcie,
    input  logic rst,
    input  logic user_reset,
    input  logic soft_rst_subsys,
    input  logic link_up,
    output logic rst_subsys,
    output logic led_state
);

    logic [LED_BLINK_BIT:0] blink_cnt;

    // --------------------------------------------------
    // Receive-side reset
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        rst_subsys <= rst || user_reset || soft_rst_subsys;
    end

    // --------------------------------------------------
    // Blink counter and LED
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // Solid when up, blink when down
    assign led_state = link_up || blink_cnt[LED_BLINK_BIT];

endmodule

`default_nettype wire

/* verilog/tlp_core_if.sv */
/*
 * 64-bit core-side TLP stream, one instance per direction.
 * The sink side always accepts on receive; the source side honors ready.
 */

`timescale 1ns/1ps
`default_nettype none

interface tlp_core_if import tlp_stream_pkg::*; ();

    logic [CORE_DATA_W-1:0] data;
    logic [CORE_KEEP_W-1:0] keep;
    logic                   last;
    logic                   valid;
    logic                   ready;
    logic [BAR_HIT_W-1:0]   bar_hit;

    // Transmit side, BAR hit only exists on receive
    modport source (
        output data,
        output keep,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  keep,
        input  last,
        input  valid,
        input  bar_hit,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/tlp_rx_packer.sv */
/*
 * Receive packer. Collects 64-bit core beats at a running dword offset
 * and strobes a 128-bit TLP beat once three or more dwords are held
 * or the packet ends. The core stream is accepted every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module tlp_rx_packer import tlp_stream_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    tlp_core_if.sink   core,
    tlp_wide_if.source wide
);

    localparam int CNT_W = $clog2(DW_PER_WIDE) + 1;

    logic [WIDE_DATA_W-1:0] pack_data;
    logic [CNT_W-1:0]       dw_count;
    logic                   last_pend;
    logic                   first_q;
    logic [BAR_HIT_W-1:0]   bar_hit_q;

    logic                   emit;
    logic [CNT_W-1:0]       next_base;
    logic [CNT_W-1:0]       next_count;

    // --------------------------------------------------
    // Output strobe and next offset
    // --------------------------------------------------
    assign emit = last_pend || (dw_count > 2);

    // A beat going out this cycle frees the whole register
    assign next_base  = emit ? '0 : dw_count;
    assign next_count = next_base + CNT_W'(1) + CNT_W'(core.keep[4]);

    assign core.ready = 1'b1;

    assign wide.tdata   = pack_data;
    assign wide.tvalid  = emit;
    assign wide.tlast   = last_pend;
    assign wide.first   = first_q;
    assign wide.bar_hit = bar_hit_q;
    assign wide.tkeepdw = {(dw_count > 3), (dw_count > 2), (dw_count > 1), 1'b1};

    // Payload, placed at the current dword offset
    always_ff @(posedge clk_pcie) begin
        if (core.valid) begin
            pack_data[32*next_base +: CORE_DATA_W] <= core.data;
        end
    end

    // --------------------------------------------------
    // Count, pending last and packet-start flag
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dw_count  <= '0;
            last_pend <= 1'b0;
            first_q   <= 1'b1;
            bar_hit_q <= '0;
        end else if (core.valid) begin
            dw_count  <= next_count;
            last_pend <= core.last;
            bar_hit_q <= core.bar_hit;
            // Next packet starts after a beat carrying last
            if (emit) begin
                first_q <= last_pend;
            end
        end else if (emit) begin
            dw_count  <= '0;
            last_pend <= 1'b0;
            first_q   <= last_pend;
        end
    end

    // An emitted beat holds one to four dwords, a run from dword 0
    a_keep_contig : assert property (
        @(posedge clk_pcie) disable iff (rst)
        wide.tvalid |-> (dw_count inside {[1:DW_PER_WIDE]})
    );

endmodule

`default_nettype wire

/* verilog/tlp_stream_pkg.sv */
/*
 * Shared widths, keep codes and types for the TLP stream width adapter.
 * Imported by the interfaces and every RTL block of the adapter.
 */

`default_nettype none

package tlp_stream_pkg;

    // --------------------------------------------------
    // Stream widths
    // --------------------------------------------------
    localparam int CORE_DATA_W    = 64;
    localparam int WIDE_DATA_W    = 128;
    localparam int CORE_KEEP_W    = 8;

    // Dwords in one wide beat, also the width of tkeepdw
    localparam int DW_PER_WIDE    = 4;

    // Core receive user field, BAR hit lives in bits 2..8
    localparam int CORE_RX_USER_W = 22;
    localparam int BAR_HIT_W      = 7;
    localparam int BAR_HIT_LSB    = 2;

    // --------------------------------------------------
    // Core byte-keep codes
    // --------------------------------------------------
    // Low dword only
    localparam logic [CORE_KEEP_W-1:0] KEEP_ONE_DW = 8'h0f;
    // Both dwords of the core beat
    localparam logic [CORE_KEEP_W-1:0] KEEP_TWO_DW = 8'hff;

    // Counter bit driving the link-down blink
    localparam int LED_BLINK_BIT  = 25;

    // Which half of a wide beat the splitter is sending
    typedef enum logic {
        SPLIT_LOW,
        SPLIT_HIGH
    } split_phase_t;

endpackage

`default_nettype wire

/* verilog/tlp_tx_splitter.sv */
/*
 * Transmit splitter. Sends each 128-bit TLP beat as one or two 64-bit
 * core beats. The wide beat is only consumed with its last core half,
 * so core back-pressure is honored on both halves.
 */

`timescale 1ns/1ps
`default_nettype none

module tlp_tx_splitter import tlp_stream_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    tlp_wide_if.sink   wide,
    tlp_core_if.source core
);

    split_phase_t phase;
    logic         has_high;
    logic         core_xfer;

    // Dword 2 valid means the beat needs a second core transfer
    assign has_high  = wide.tkeepdw[2];
    assign core_xfer = core.valid && core.ready;

    // --------------------------------------------------
    // Core beat select
    // --------------------------------------------------
    always_comb begin
        core.valid = wide.tvalid;
        if (phase == SPLIT_HIGH) begin
            core.data   = wide.tdata[WIDE_DATA_W-1:CORE_DATA_W];
            core.keep   = wide.tkeepdw[3] ? KEEP_TWO_DW : KEEP_ONE_DW;
            core.last   = wide.tlast;
            wide.tready = core.ready;
        end else begin
            core.data   = wide.tdata[CORE_DATA_W-1:0];
            core.keep   = wide.tkeepdw[1] ? KEEP_TWO_DW : KEEP_ONE_DW;
            core.last   = wide.tlast && !has_high;
            wide.tready = core.ready && !has_high;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            phase <= SPLIT_LOW;
        end else if (core_xfer) begin
            if (phase == SPLIT_LOW && has_high) begin
                phase <= SPLIT_HIGH;
            end else begin
                phase <= SPLIT_LOW;
            end
        end
    end

    // Relies on the wide source holding its beat until tready
    a_hold_stall : assert property (
        @(posedge clk_pcie) disable iff (rst)
        (core.valid && !core.ready) |=>
            ($stable(core.data) && $stable(core.keep) && $stable(core.last))
    );

    // The high phase only serves a held beat with dword 2 valid
    a_high_needs_dw2 : assert property (
        @(posedge clk_pcie) disable iff (rst)
        (phase == SPLIT_HIGH) |-> (wide.tvalid && has_high)
    );

endmodule

`default_nettype wire

/* verilog/tlp_wide_if.sv */
/*
 * 128-bit TLP stream with a dword keep field and packet side bits.
 * Receive output is a one-cycle strobe; transmit input uses tvalid/tready.
 */

`timescale 1ns/1ps
`default_nettype none

interface tlp_wide_if import tlp_stream_pkg::*; ();

    logic [WIDE_DATA_W-1:0] tdata;
    logic [DW_PER_WIDE-1:0] tkeepdw;
    logic                   tlast;
    logic                   tvalid;
    logic                   tready;
    // Start of packet marker
    logic                   first;
    logic [BAR_HIT_W-1:0]   bar_hit;

    // Packer side, a strobe with no ready
    modport source (
        output tdata,
        output tkeepdw,
        output tlast,
        output tvalid,
        output first,
        output bar_hit
    );

    // Splitter side
    modport sink (
        input  tdata,
        input  tkeepdw,
        input  tlast,
        input  tvalid,
        output tready
    );

endinterface

`default_nettype wire

/* verilog/tlp_width_top.sv */
/*
 * Top level of the TLP stream width adapter. Maps the plain core and
 * TLP ports onto one core and one wide stream per direction, and wires
 * the packer, the splitter and the reset/LED block together.
 */

`timescale 1ns/1ps
`default_nettype none

module tlp_width_top import tlp_stream_pkg::*; (
    input  logic                      clk_pcie,
    input  logic                      rst,
    input  logic                      user_reset,
    input  logic                      soft_rst_subsys,
    input  logic                      link_up,

    // Core receive stream
    input  logic [CORE_DATA_W-1:0]    core_rx_data,
    input  logic [CORE_KEEP_W-1:0]    core_rx_keep,
    input  logic                      core_rx_last,
    input  logic                      core_rx_valid,
    input  logic [CORE_RX_USER_W-1:0] core_rx_user,

    // Packed receive TLPs
    output logic [WIDE_DATA_W-1:0]    wide_rx_data,
    output logic [DW_PER_WIDE-1:0]    wide_rx_keepdw,
    output logic                      wide_rx_last,
    output logic                      wide_rx_valid,
    output logic                      wide_rx_first,
    output logic [BAR_HIT_W-1:0]      wide_rx_bar_hit,

    // Transmit TLPs
    input  logic [WIDE_DATA_W-1:0]    wide_tx_data,
    input  logic [DW_PER_WIDE-1:0]    wide_tx_keepdw,
    input  logic                      wide_tx_last,
    input  logic                      wide_tx_valid,
    output logic                      wide_tx_ready,

    // Core transmit stream
    output logic [CORE_DATA_W-1:0]    core_tx_data,
    output logic [CORE_KEEP_W-1:0]    core_tx_keep,
    output logic                      core_tx_last,
    output logic                      core_tx_valid,
    input  logic                      core_tx_ready,

    output logic                      led_state
);

    logic rst_subsys;

    tlp_core_if rx_core ();
    tlp_wide_if rx_wide ();
    tlp_wide_if tx_wide ();
    tlp_core_if tx_core ();

    // --------------------------------------------------
    // Receive path
    // --------------------------------------------------
    assign rx_core.data    = core_rx_data;
    assign rx_core.keep    = core_rx_keep;
    assign rx_core.last    = core_rx_last;
    assign rx_core.valid   = core_rx_valid;
    assign rx_core.bar_hit = core_rx_user[BAR_HIT_LSB +: BAR_HIT_W];

    assign wide_rx_data    = rx_wide.tdata;
    assign wide_rx_keepdw  = rx_wide.tkeepdw;
    assign wide_rx_last    = rx_wide.tlast;
    assign wide_rx_valid   = rx_wide.tvalid;
    assign wide_rx_first   = rx_wide.first;
    assign wide_rx_bar_hit = rx_wide.bar_hit;

    // --------------------------------------------------
    // Transmit path
    // --------------------------------------------------
    assign tx_wide.tdata   = wide_tx_data;
    assign tx_wide.tkeepdw = wide_tx_keepdw;
    assign tx_wide.tlast   = wide_tx_last;
    assign tx_wide.tvalid  = wide_tx_valid;
    assign wide_tx_ready   = tx_wide.tready;

    assign core_tx_data    = tx_core.data;
    assign core_tx_keep    = tx_core.keep;
    assign core_tx_last    = tx_core.last;
    assign core_tx_valid   = tx_core.valid;
    assign tx_core.ready   = core_tx_ready;

    pcie_status_ctrl u_status (
        .clk_pcie        (clk_pcie),
        .rst             (rst),
        .user_reset      (user_reset),
        .soft_rst_subsys (soft_rst_subsys),
        .link_up         (link_up),
        .rst_subsys      (rst_subsys),
        .led_state       (led_state)
    );

    // Receive side restarts on any subsystem reset
    tlp_rx_packer u_rx_packer (
        .clk_pcie (clk_pcie),
        .rst      (rst_subsys),
        .core     (rx_core.sink),
        .wide     (rx_wide.source)
    );

    tlp_tx_splitter u_tx_splitter (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .wide     (tx_wide.sink),
        .core     (tx_core.source)
    );

endmodule

`default_nettype wire
